// ==== source/uart_line_pkg.sv ====
package uart_line_pkg;

   // Width of the bit period and of the run timer
   localparam int PERIOD_W = 24;

   typedef logic [PERIOD_W-1:0] period_t;

   // Runs shorter than this are glitches
   localparam period_t MIN_RUN = period_t'(2);

   // Held from reset until the first valid run
   localparam period_t PERIOD_UNKNOWN = '1;

   // Serial line timing seen by receiver and transmitter
   typedef struct packed {
      logic    locked;   // Period measured at least once
      period_t period;   // Clock cycles per bit
   } line_status_t;

endpackage

// ==== source/uart_stream_pkg.sv ====
package uart_stream_pkg;

   // Transmit buffer entries, also the host's initial credits
   localparam int TX_DEPTH = 4;
   localparam int TX_PTR_W = $clog2(TX_DEPTH);

   // Holds 0 to 4
   typedef logic [2:0] credit_cnt_t;

   // Ceiling of the receive credit counter
   localparam credit_cnt_t RX_CREDITS_MAX = credit_cnt_t'(4);

   // One byte on the host side
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } byte_beat_t;

   typedef struct packed {
      logic overrun;   // Sticky, byte lost for lack of credit
      logic rx_busy;   // Frame being received
   } uart_status_t;

endpackage

// ==== source/baud_detect.sv ====
`timescale 1ns/10ps

module baud_detect
   import uart_line_pkg::*;
(
   input  logic         i_clk,
   input  logic         i_nrst,
   input  logic         i_line,
   output line_status_t o_line
);

   logic    line_q;
   period_t run_q;
   period_t period_q;
   logic    locked_q;
   logic    edge_seen;
   logic    run_valid;

   assign edge_seen = i_line != line_q;

   // Length of the run that ends at this edge
   assign run_valid = edge_seen && (run_q >= MIN_RUN) && (run_q < period_q);

   // Timer starts saturated so the run before the first edge never counts
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         line_q   <= 1'b1;   // Idle line
         run_q    <= '1;
         period_q <= PERIOD_UNKNOWN;
         locked_q <= 1'b0;
      end else begin
         line_q <= i_line;
         if (edge_seen) begin
            run_q <= period_t'(1);   // Edge cycle is the first of the new run
         end else if (!(&run_q)) begin
            run_q <= run_q + 1'b1;
         end
         if (run_valid) begin
            period_q <= run_q;
            locked_q <= 1'b1;
         end
      end
   end

   assign o_line = '{locked: locked_q, period: period_q};

   period_never_rises: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_line.period <= $past(o_line.period)
   );

   lock_never_falls: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      $past(o_line.locked) |-> o_line.locked
   );

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx
   import uart_line_pkg::*, uart_stream_pkg::*;
(
   input  logic         i_clk,
   input  logic         i_nrst,
   input  logic         i_line,
   input  line_status_t i_status,
   input  logic         i_rx_credit,
   output byte_beat_t   o_rx_beat,
   output uart_status_t o_status
);

   typedef enum logic [1:0] {
      RX_WAIT,    // Line must stay high for over a period
      RX_IDLE,
      RX_START,
      RX_DATA
   } rx_state_t;

   rx_state_t   state_q;
   period_t     cnt_q;
   period_t     frame_period;
   logic [2:0]  bit_q;
   logic [7:0]  shift_q;
   logic        valid_q;
   logic        overrun_q;
   credit_cnt_t credits_q;
   credit_cnt_t credits_next;
   logic        period_same;
   logic        last_bit;
   logic        take;

   assign period_same = i_status.period == frame_period;
   assign last_bit    = (state_q == RX_DATA) && (cnt_q == '0) && (bit_q == 3'd7) && period_same;
   assign take        = last_bit && (credits_q != '0);

   always_comb begin
      credits_next = credits_q;
      if (take) begin
         credits_next = credits_next - 1'b1;
      end
      if (i_rx_credit && (credits_next != RX_CREDITS_MAX)) begin
         credits_next = credits_next + 1'b1;   // Saturates
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q   <= RX_WAIT;
         cnt_q     <= '0;
         bit_q     <= '0;
         valid_q   <= 1'b0;
         overrun_q <= 1'b0;
         credits_q <= '0;
      end else begin
         credits_q <= credits_next;
         valid_q   <= take;
         if (last_bit && (credits_q == '0)) begin
            overrun_q <= 1'b1;   // Byte dropped
         end
         case (state_q)
            RX_WAIT: begin
               if (!i_line || !i_status.locked) begin
                  cnt_q <= '0;
               end else if (cnt_q >= i_status.period) begin
                  state_q <= RX_IDLE;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            RX_IDLE: begin
               if (!i_line) begin
                  state_q <= RX_START;
                  cnt_q   <= (i_status.period >> 1) - 1'b1;   // To middle of start bit
               end
            end
            RX_START, RX_DATA: begin
               if (!period_same) begin
                  state_q <= RX_WAIT;   // Period lowered during the frame
                  cnt_q   <= '0;
               end else if (cnt_q != '0) begin
                  cnt_q <= cnt_q - 1'b1;
               end else if (state_q == RX_START) begin
                  if (i_line) begin
                     state_q <= RX_WAIT;   // False start
                     cnt_q   <= '0;
                  end else begin
                     state_q <= RX_DATA;
                     cnt_q   <= frame_period - 1'b1;
                     bit_q   <= '0;
                  end
               end else if (bit_q == 3'd7) begin
                  state_q <= RX_WAIT;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= frame_period - 1'b1;
                  bit_q <= bit_q + 1'b1;
               end
            end
            default: state_q <= RX_WAIT;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state_q == RX_IDLE) begin
         frame_period <= i_status.period;
      end
      if ((state_q == RX_DATA) && (cnt_q == '0)) begin
         shift_q <= {i_line, shift_q[7:1]};   // LSB first
      end
   end

   assign o_rx_beat = '{valid: valid_q, data: shift_q};
   assign o_status  = '{overrun: overrun_q,
                        rx_busy: (state_q == RX_START) || (state_q == RX_DATA)};

   beat_needs_credit: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_rx_beat.valid |-> ($past(credits_q) != '0)
   );

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx
   import uart_line_pkg::*, uart_stream_pkg::*;
(
   input  logic         i_clk,
   input  logic         i_nrst,
   input  byte_beat_t   i_tx_beat,
   input  line_status_t i_status,
   output logic         o_tx,
   output logic         o_tx_credit
);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP,
      TX_GUARD    // Extra period of idle high
   } tx_state_t;

   logic [7:0]          buf_mem [TX_DEPTH];
   logic [TX_PTR_W-1:0] wr_ptr;
   logic [TX_PTR_W-1:0] rd_ptr;
   credit_cnt_t         fill_q;
   logic                buf_full;
   logic                wr_en;
   logic                take;
   tx_state_t           state_q;
   period_t             cnt_q;
   period_t             frame_period;
   logic [2:0]          bit_q;
   logic [7:0]          shift_q;
   logic                tx_q;
   logic                bit_end;
   logic                shift_en;

   assign buf_full = fill_q == credit_cnt_t'(TX_DEPTH);
   assign wr_en    = i_tx_beat.valid && !buf_full;
   assign take     = (state_q == TX_IDLE) && i_status.locked && (fill_q != '0);
   assign bit_end  = cnt_q == '0;
   assign shift_en = bit_end && ((state_q == TX_START) ||
                                 ((state_q == TX_DATA) && (bit_q != 3'd7)));

   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         buf_mem[wr_ptr] <= i_tx_beat.data;
      end
      if (take) begin
         shift_q      <= buf_mem[rd_ptr];
         frame_period <= i_status.period;   // Frame keeps its period
      end else if (shift_en) begin
         shift_q <= shift_q >> 1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         fill_q  <= '0;
         state_q <= TX_IDLE;
         cnt_q   <= '0;
         bit_q   <= '0;
         tx_q    <= 1'b1;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (take) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, take})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase

         if (state_q == TX_IDLE) begin
            if (take) begin
               state_q <= TX_START;
               cnt_q   <= i_status.period - 1'b1;
               tx_q    <= 1'b0;   // Start bit
            end
         end else if (!bit_end) begin
            cnt_q <= cnt_q - 1'b1;
         end else begin
            cnt_q <= frame_period - 1'b1;
            case (state_q)
               TX_START: begin
                  state_q <= TX_DATA;
                  bit_q   <= '0;
                  tx_q    <= shift_q[0];
               end
               TX_DATA: begin
                  if (bit_q == 3'd7) begin
                     state_q <= TX_STOP;
                     tx_q    <= 1'b1;
                  end else begin
                     bit_q <= bit_q + 1'b1;
                     tx_q  <= shift_q[0];
                  end
               end
               TX_STOP:  state_q <= TX_GUARD;
               default:  state_q <= TX_IDLE;
            endcase
         end
      end
   end

   assign o_tx        = tx_q;
   assign o_tx_credit = take;   // One credit back per byte taken

   // Host wrote without holding a credit
   write_not_full: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      i_tx_beat.valid |-> !buf_full
   );

endmodule

// ==== source/uart_autobaud_top.sv ====
`timescale 1ns/10ps

module uart_autobaud_top
   import uart_line_pkg::*, uart_stream_pkg::*;
(
   input  logic         i_clk,
   input  logic         i_nrst,
   input  logic         i_rx,
   input  byte_beat_t   i_tx_beat,
   input  logic         i_rx_credit,
   output logic         o_tx,
   output logic         o_tx_credit,
   output byte_beat_t   o_rx_beat,
   output line_status_t o_line,
   output uart_status_t o_status
);

   logic         rx_meta;
   logic         rx_sync;
   line_status_t line_status;

   // Two flop synchronizer, idle high out of reset
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   baud_detect baud_detect_i (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_line (rx_sync),
      .o_line (line_status)
   );

   uart_rx uart_rx_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_line      (rx_sync),
      .i_status    (line_status),
      .i_rx_credit (i_rx_credit),
      .o_rx_beat   (o_rx_beat),
      .o_status    (o_status)
   );

   uart_tx uart_tx_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_tx_beat   (i_tx_beat),
      .i_status    (line_status),
      .o_tx        (o_tx),
      .o_tx_credit (o_tx_credit)
   );

   assign o_line = line_status;

endmodule

// ==== test/tb_uart_autobaud.sv ====
`timescale 1ns/10ps

module tb_uart_autobaud
   import uart_line_pkg::*, uart_stream_pkg::*;
();

   logic         clk;
   logic         nrst;
   logic         rx;
   logic         rx_credit;
   byte_beat_t   tx_beat;
   logic         tx;
   logic         tx_credit;
   byte_beat_t   rx_beat;
   line_status_t line;
   uart_status_t status;

   logic [63:0]  ops[$];
   int           pers[$];
   logic [7:0]   vals[$];
   logic [7:0]   tx_expect[$];   // Bytes written but not yet seen on o_tx
   logic [7:0]   rx_got[$];
   int           value_errors = 0;
   int           other_errors = 0;
   int           cycles = 0;
   int           limit = 0;
   logic [31:0]  rnd = 32'h6f93b574;
   period_t      exp_period = PERIOD_UNKNOWN;
   logic         exp_locked = 1'b0;
   logic         exp_overrun = 1'b0;
   int           tx_credits = TX_DEPTH;
   int           credit_pulses = 0;
   int           tx_written = 0;

   uart_autobaud_top dut_i (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_rx        (rx),
      .i_tx_beat   (tx_beat),
      .i_rx_credit (rx_credit),
      .o_tx        (tx),
      .o_tx_credit (tx_credit),
      .o_rx_beat   (rx_beat),
      .o_line      (line),
      .o_status    (status)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if ((limit != 0) && (cycles > limit)) begin
         $display("Timeout after %0d cycles, DUT stopped responding", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_line(input string name, input line_status_t exp, input line_status_t act);
      if (act !== exp) begin
         value_errors++;
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input byte_beat_t exp, input byte_beat_t act);
      if (act !== exp) begin
         value_errors++;
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_status(input string name, input uart_status_t exp,
                               input uart_status_t act);
      if (act !== exp) begin
         value_errors++;
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   // Returns 1 ns after the rising edge
   task automatic hold(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic skip_negedges(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Frame with LSB first data followed by a random idle gap
   task automatic send_frame(input int per, input logic [7:0] data);
      int gap;
      rnd = xorshift32(rnd);
      gap = 4 * per + int'(rnd % (2 * per));
      rx = 1'b0;
      hold(per);
      for (int k = 0; k < 8; k++) begin
         rx = data[k];
         hold(per);
      end
      rx = 1'b1;
      hold(per + gap);
   endtask

   task automatic drain_tx();
      while (tx_expect.size() != 0) hold(1);
      hold(2);
   endtask

   task automatic do_sync(input int per);
      line_status_t exp_line;
      if (exp_locked) drain_tx();   // No frame in flight across a period change
      if (period_t'(per) < exp_period) exp_period = period_t'(per);
      exp_locked = 1'b1;
      send_frame(per, 8'h55);
      exp_line = '{locked: 1'b1, period: exp_period};
      check_line("o_line", exp_line, line);
   endtask

   task automatic do_rx(input int per, input logic [7:0] data, input logic granted);
      byte_beat_t   exp_beat;
      byte_beat_t   got_beat;
      uart_status_t exp_st;
      send_frame(per, data);
      if (!granted) begin
         exp_overrun = 1'b1;
      end else if (rx_got.size() == 0) begin
         other_errors++;
         $display("No byte on o_rx_beat for sent byte %h", data);
      end else begin
         exp_beat = '{valid: 1'b1, data: data};
         got_beat = '{valid: 1'b1, data: rx_got.pop_front()};
         check_byte("o_rx_beat", exp_beat, got_beat);
      end
      if (rx_got.size() != 0) begin
         other_errors++;
         $display("Unexpected byte on o_rx_beat after sending %h", data);
         rx_got.delete();
      end
      exp_st = '{overrun: exp_overrun, rx_busy: 1'b0};
      check_status("o_status", exp_st, status);
   endtask

   task automatic grant_credits(input int n);
      repeat (n) begin
         rx_credit = 1'b1;
         hold(1);
      end
      rx_credit = 1'b0;
   endtask

   task automatic write_tx(input logic [7:0] data);
      while (tx_credits == 0) hold(1);
      tx_beat = '{valid: 1'b1, data: data};
      tx_credits--;
      tx_written++;
      tx_expect.push_back(data);
      hold(1);
      tx_beat = '{valid: 1'b0, data: 8'h00};
   endtask

   // Outputs sampled on the falling edge
   always @(negedge clk) begin
      if (nrst) begin
         if (rx_beat.valid) rx_got.push_back(rx_beat.data);
         if (tx_credit) begin
            credit_pulses++;
            tx_credits++;
            if (!line.locked) begin
               other_errors++;
               $display("Transmit credit returned before the period was locked");
            end
            if (tx_credits > TX_DEPTH) begin
               other_errors++;
               $display("More transmit credits returned than bytes written");
            end
         end
      end
   end

   initial begin : tx_decode
      logic [7:0] data;
      logic       start_bit;
      logic       stop_bit;
      byte_beat_t exp_beat;
      byte_beat_t got_beat;
      @(posedge nrst);
      forever begin
         @(negedge clk);
         if (tx === 1'b0) begin
            if (!line.locked) begin
               other_errors++;
               $display("Activity on o_tx before the period was locked");
            end
            skip_negedges(int'(exp_period) / 2);   // Middle of start bit
            start_bit = tx;
            for (int k = 0; k < 8; k++) begin
               skip_negedges(int'(exp_period));
               data[k] = tx;
            end
            skip_negedges(int'(exp_period));
            stop_bit = tx;
            if ((start_bit !== 1'b0) || (stop_bit !== 1'b1)) begin
               other_errors++;
               $display("Bad start or stop bit on o_tx at %0t", $time);
            end
            if (tx_expect.size() == 0) begin
               other_errors++;
               $display("Byte %h on o_tx that was never written", data);
            end else begin
               exp_beat = '{valid: 1'b1, data: tx_expect.pop_front()};
               got_beat = '{valid: 1'b1, data: data};
               check_byte("o_tx", exp_beat, got_beat);
            end
         end
      end
   end

   initial begin : main
      int            fd;
      int            code;
      int            per;
      logic [7:0]    val;
      logic [63:0]   op;
      logic [2047:0] comment;
      int            max_per;
      int            n_tx;
      line_status_t  exp_line;
      uart_status_t  exp_st;
      nrst      = 1'b0;
      rx        = 1'b1;
      rx_credit = 1'b0;
      tx_beat   = '{valid: 1'b0, data: 8'h00};
      max_per   = 1;
      n_tx      = 0;

      fd = $fopen("test/uart_stim.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Cannot open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            op = '0;
            code = $fscanf(fd, "%s", op);
            if (code != 1) break;
            if (op == "#") begin
               code = $fgets(comment, fd);
            end else begin
               code = $fscanf(fd, "%d %h", per, val);
               ops.push_back(op);
               pers.push_back(per);
               vals.push_back(val);
            end
         end
         $fclose(fd);
      end

      // 12 periods per frame plus at most 6 of gap
      foreach (ops[i]) begin
         if ((ops[i] == "sync") || (ops[i] == "rx") || (ops[i] == "nocredit")) begin
            limit += 18 * pers[i];
            if (pers[i] > max_per) max_per = pers[i];
         end else if (ops[i] == "credits") begin
            limit += int'(vals[i]) + 1;
         end else begin
            n_tx++;
         end
      end
      limit += n_tx * 12 * max_per + 16 + 1000;

      repeat (16) @(posedge clk);
      #1;
      nrst = 1'b1;

      exp_line = '{locked: 1'b0, period: PERIOD_UNKNOWN};
      exp_st   = '{overrun: 1'b0, rx_busy: 1'b0};
      check_line("o_line", exp_line, line);
      check_status("o_status", exp_st, status);
      if ((tx !== 1'b1) || (tx_credit !== 1'b0) || (rx_beat.valid !== 1'b0)) begin
         other_errors++;
         $display("Outputs not idle after reset");
      end

      foreach (ops[i]) begin
         if (ops[i] == "sync") do_sync(pers[i]);
         else if (ops[i] == "rx") do_rx(pers[i], vals[i], 1'b1);
         else if (ops[i] == "nocredit") do_rx(pers[i], vals[i], 1'b0);
         else if (ops[i] == "tx") write_tx(vals[i]);
         else if (ops[i] == "credits") grant_credits(int'(vals[i]));
         else begin
            other_errors++;
            $display("Unknown operation in stimulus line %0d", i);
         end
      end

      drain_tx();
      hold(10);
      if ((credit_pulses != tx_written) || (tx_credits != TX_DEPTH)) begin
         other_errors++;
         $display("Saw %0d transmit credits for %0d bytes written", credit_pulses, tx_written);
      end

      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if ((value_errors == 0) && (other_errors == 0)) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== test/uart_stim.txt ====
# op period value: period in clock cycles (decimal), value in hex
# sync, rx, nocredit send a frame; tx writes the value; credits grants value credits
tx 0 a5
tx 0 3c
tx 0 01
tx 0 f0
sync 16 55
credits 0 3
rx 16 12
rx 16 ab
rx 16 00
tx 0 7e
tx 0 99
sync 10 55
credits 0 4
rx 10 c3
rx 10 5a
rx 10 ff
rx 10 80
tx 0 81
tx 0 ff
tx 0 00
nocredit 10 99
credits 0 2
rx 10 e7
rx 10 18
sync 20 55
credits 0 1
rx 10 6d
tx 0 42
tx 0 24
sync 7 55
credits 0 3
rx 7 b6
rx 7 49
rx 7 0f
tx 0 d2
tx 0 5e

// ==== tb.f ====
source/uart_line_pkg.sv
source/uart_stream_pkg.sv
source/baud_detect.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_autobaud_top.sv
test/tb_uart_autobaud.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_autobaud
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
